/* design/bus_ctrl.sv */
`timescale 1ns/1ps

module bus_ctrl import soc_pkg::*; (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [ADDR_W-1:0] wb_adr,
  input  logic [DATA_W-1:0] wb_wdata,
  output logic [DATA_W-1:0] wb_rdata,
  output logic              wb_ack,
  output logic              wb_err,
  output logic              mem_en,
  output logic              mem_we,
  output logic [MEM_AW-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic              reg_wr,
  output logic              reg_rd,
  output mmio_reg_e         reg_sel,
  output logic [DATA_W-1:0] reg_wdata,
  input  logic [DATA_W-1:0] reg_rdata,
  input  logic              tx_busy
);

  bus_state_e        state;
  logic [ADDR_W-1:0] mem_ofs;
  logic [ADDR_W-1:0] mmio_ofs;
  logic              dec_mem;
  logic              dec_reg;
  mmio_reg_e         dec_sel;

  logic              hit_mem_q;
  logic              hit_reg_q;
  logic              we_q;
  logic [MEM_AW-1:0] mem_addr_q;
  mmio_reg_e         sel_q;
  logic [DATA_W-1:0] wdata_q;

  // address decode, used only while idle
  always_comb begin
    mem_ofs  = wb_adr - MEM_BASE;
    mmio_ofs = wb_adr - MMIO_BASE;
    dec_mem  = mem_ofs < ADDR_W'(MEM_WORDS * 4);
    dec_reg  = 1'b1;
    dec_sel  = REG_TXDATA;
    case (mmio_ofs)
      TXDATA_OFS: dec_sel = REG_TXDATA;
      RXDATA_OFS: dec_sel = REG_RXDATA;
      STATUS_OFS: dec_sel = REG_STATUS;
      default:    dec_reg = 1'b0;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      hit_mem_q <= 1'b0;
      hit_reg_q <= 1'b0;
      we_q      <= 1'b0;
      wb_ack    <= 1'b0;
      wb_err    <= 1'b0;
    end else begin
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
      case (state)
        ST_IDLE: begin
          // ack still high means the master has not seen it yet
          if (wb_cyc && wb_stb && !wb_ack && !wb_err) begin
            hit_mem_q <= dec_mem;
            hit_reg_q <= dec_reg;
            we_q      <= wb_we;
            if (dec_reg && dec_sel == REG_TXDATA && wb_we && tx_busy) begin
              state <= ST_WAIT_TX;
            end else begin
              state <= ST_ACCESS;
            end
          end
        end
        ST_WAIT_TX: begin
          if (!tx_busy) begin
            state <= ST_ACCESS;
          end
        end
        ST_ACCESS: state <= ST_RESP;
        ST_RESP: begin
          wb_ack <= hit_mem_q | hit_reg_q;
          wb_err <= ~(hit_mem_q | hit_reg_q);
          state  <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == ST_IDLE) begin
      mem_addr_q <= mem_ofs[MEM_AW+1:2];
      sel_q      <= dec_sel;
      wdata_q    <= wb_wdata;
    end
    if (state == ST_RESP) begin
      if (hit_mem_q) begin
        wb_rdata <= mem_rdata;
      end else if (hit_reg_q) begin
        wb_rdata <= reg_rdata;
      end else begin
        wb_rdata <= '0;
      end
    end
  end

  // target strobes for the single access cycle
  assign mem_en    = (state == ST_ACCESS) && hit_mem_q;
  assign mem_we    = mem_en && we_q;
  assign mem_addr  = mem_addr_q;
  assign mem_wdata = wdata_q;
  assign reg_wr    = (state == ST_ACCESS) && hit_reg_q && we_q;
  assign reg_rd    = (state == ST_ACCESS) && hit_reg_q && !we_q;
  assign reg_sel   = sel_q;
  assign reg_wdata = wdata_q;

endmodule

/* design/scratch_mem.sv */
`timescale 1ns/1ps

module scratch_mem import soc_pkg::*; (
  input  logic              clock,
  input  logic              mem_en,
  input  logic              mem_we,
  input  logic [MEM_AW-1:0] mem_addr,
  input  logic [DATA_W-1:0] mem_wdata,
  output logic [DATA_W-1:0] mem_rdata
);

  logic [DATA_W-1:0] mem [MEM_WORDS];

  // one cycle read latency
  always_ff @(posedge clock) begin
    if (mem_en) begin
      if (mem_we) begin
        mem[mem_addr] <= mem_wdata;
      end else begin
        mem_rdata <= mem[mem_addr];
      end
    end
  end

endmodule

/* design/soc_pkg.sv */
package soc_pkg;

  // bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // scratch memory, word addressed
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = 8;

  // address map
  localparam logic [ADDR_W-1:0] MEM_BASE  = 16'h0000;
  localparam logic [ADDR_W-1:0] MMIO_BASE = 16'h8000;

  // uart register offsets from MMIO_BASE
  localparam logic [ADDR_W-1:0] TXDATA_OFS = 16'h0000;
  localparam logic [ADDR_W-1:0] RXDATA_OFS = 16'h0004;
  localparam logic [ADDR_W-1:0] STATUS_OFS = 16'h0008;

  // serial bit timing
  localparam int CLKS_PER_BIT = 8;
  localparam int CLKS_W       = 4;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_TX,
    ST_ACCESS,
    ST_RESP
  } bus_state_e;

  typedef enum logic [1:0] {
    REG_TXDATA,
    REG_RXDATA,
    REG_STATUS
  } mmio_reg_e;

endpackage

/* design/soc_top.sv */
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [ADDR_W-1:0] wb_adr,
  input  logic [DATA_W-1:0] wb_wdata,
  output logic [DATA_W-1:0] wb_rdata,
  output logic              wb_ack,
  output logic              wb_err,
  output logic              tx,
  input  logic              rx,
  output logic              irq
);

  logic              mem_en;
  logic              mem_we;
  logic [MEM_AW-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic [DATA_W-1:0] mem_rdata;

  logic              reg_wr;
  logic              reg_rd;
  mmio_reg_e         reg_sel;
  logic [DATA_W-1:0] reg_wdata;
  logic [DATA_W-1:0] reg_rdata;
  logic              tx_busy;

  bus_ctrl ctrl_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_wdata  (wb_wdata),
    .wb_rdata  (wb_rdata),
    .wb_ack    (wb_ack),
    .wb_err    (wb_err),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_sel   (reg_sel),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .tx_busy   (tx_busy)
  );

  scratch_mem mem_i (
    .clock     (clock),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  uart_mmio uart_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_sel   (reg_sel),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .tx_busy   (tx_busy),
    .irq       (irq),
    .tx        (tx),
    .rx        (rx)
  );

endmodule

/* design/uart_mmio.sv */
`timescale 1ns/1ps

module uart_mmio import soc_pkg::*; (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              reg_wr,
  input  logic              reg_rd,
  input  mmio_reg_e         reg_sel,
  input  logic [DATA_W-1:0] reg_wdata,
  output logic [DATA_W-1:0] reg_rdata,
  output logic              tx_busy,
  output logic              irq,
  output logic              tx,
  input  logic              rx
);

  logic       tx_start;
  logic [7:0] tx_byte;
  logic       eng_busy;
  logic       rx_done;
  logic [7:0] rx_byte;
  logic       rx_valid;
  logic [7:0] rx_hold;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tx_start <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      tx_start <= reg_wr && (reg_sel == REG_TXDATA);
      // new byte wins over a read in the same cycle
      if (rx_done) begin
        rx_valid <= 1'b1;
      end else if (reg_rd && reg_sel == REG_RXDATA) begin
        rx_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reg_wr && reg_sel == REG_TXDATA) begin
      tx_byte <= reg_wdata[7:0];
    end
    if (rx_done) begin
      rx_hold <= rx_byte;
    end
    if (reg_rd) begin
      case (reg_sel)
        REG_RXDATA: reg_rdata <= {{(DATA_W-8){1'b0}}, rx_hold};
        REG_STATUS: reg_rdata <= {{(DATA_W-2){1'b0}}, rx_valid, tx_busy};
        default:    reg_rdata <= '0;
      endcase
    end
  end

  // busy covers the cycle between the write and the engine start
  assign tx_busy = eng_busy | tx_start;
  assign irq     = rx_valid;

  uart_tx tx_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (eng_busy),
    .tx       (tx)
  );

  uart_rx rx_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_done (rx_done),
    .rx_byte (rx_byte)
  );

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import soc_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  logic       rx,
  output logic       rx_done,
  output logic [7:0] rx_byte
);

  logic              rx_meta;
  logic              rx_sync;
  logic              active;
  logic [CLKS_W-1:0] clk_cnt;
  logic [3:0]        bit_cnt;
  logic              sample;

  assign sample = active && (clk_cnt == CLKS_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      active  <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_done <= 1'b0;
      if (!active) begin
        if (!rx_sync) begin
          // half bit head start puts samples mid bit
          active  <= 1'b1;
          clk_cnt <= CLKS_W'(CLKS_PER_BIT / 2);
          bit_cnt <= '0;
        end
      end else if (sample) begin
        clk_cnt <= '0;
        bit_cnt <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd0 && rx_sync) begin
          // glitch, not a start bit
          active <= 1'b0;
        end else if (bit_cnt == 4'd9) begin
          active  <= 1'b0;
          rx_done <= rx_sync;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
      rx_byte <= {rx_sync, rx_byte[7:1]};
    end
  end

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx import soc_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       tx
);

  logic [CLKS_W-1:0] clk_cnt;
  logic [3:0]        bit_cnt;
  logic [8:0]        shift_q;
  logic              bit_tick;
  logic              load;

  assign load     = tx_start && !tx_busy;
  assign bit_tick = tx_busy && (clk_cnt == CLKS_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
      tx      <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (load) begin
      // start bit goes out right away
      tx_busy <= 1'b1;
      tx      <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (tx_busy) begin
      if (bit_tick) begin
        clk_cnt <= '0;
        if (bit_cnt == 4'd9) begin
          tx_busy <= 1'b0;
          tx      <= 1'b1;
        end else begin
          tx      <= shift_q[0];
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // data bits LSB first, stop bit on top
  always_ff @(posedge clock) begin
    if (load) begin
      shift_q <= {1'b1, tx_byte};
    end else if (bit_tick) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

endmodule

/* flist.f */
design/soc_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_mmio.sv
design/scratch_mem.sv
design/bus_ctrl.sv
design/soc_top.sv
sim/tb_checker.sv
sim/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_top -f flist.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"

/* sim/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import soc_pkg::*; (
  input logic              clock,
  input logic              rst_n,
  input logic              wb_cyc,
  input logic              wb_stb,
  input logic              wb_we,
  input logic [ADDR_W-1:0] wb_adr,
  input logic [DATA_W-1:0] wb_wdata,
  input logic [DATA_W-1:0] wb_rdata,
  input logic              wb_ack,
  input logic              wb_err,
  input logic              tx,
  input logic              rx,
  input logic              irq,
  input int                test_num
);

  logic [DATA_W-1:0] mem_model [int];
  logic [7:0]        tx_q [$];
  int                tx_pending;
  logic              rx_held;
  logic [7:0]        rx_model;
  int                cur_test;
  int                test_errs;
  int                n_pass;
  int                n_fail;
  int                cycle;
  int                start_cycle;
  logic              in_req;

  initial begin
    tx_pending = 0;
    rx_held    = 1'b0;
    rx_model   = '0;
    cur_test   = 0;
    test_errs  = 0;
    n_pass     = 0;
    n_fail     = 0;
    cycle      = 0;
    start_cycle = 0;
    in_req     = 1'b0;
  end

  task automatic compare(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h exp %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_response();
    logic is_mem;
    logic is_reg;
    logic is_txw;
    is_mem = wb_adr < ADDR_W'(MEM_WORDS * 4);
    is_reg = wb_adr == MMIO_BASE + TXDATA_OFS || wb_adr == MMIO_BASE + RXDATA_OFS ||
             wb_adr == MMIO_BASE + STATUS_OFS;
    is_txw = wb_we && wb_adr == MMIO_BASE + TXDATA_OFS;
    if (!is_txw && cycle - start_cycle != 2) begin
      $display("response at address %h came %0d cycles after the request, not 2",
               wb_adr, cycle - start_cycle);
      test_errs++;
    end
    if (wb_ack == wb_err || wb_ack != (is_mem || is_reg)) begin
      $display("wrong response kind at address %h: ack %h err %h", wb_adr, wb_ack, wb_err);
      test_errs++;
    end else if (is_mem && wb_we) begin
      mem_model[int'(wb_adr)] = wb_wdata;
    end else if (is_mem) begin
      compare("wb_rdata", wb_rdata, mem_model[int'(wb_adr)]);
    end else if (is_txw) begin
      if (tx_pending != 0) begin
        $display("TXDATA write accepted while a frame was still pending");
        test_errs++;
      end
      tx_q.push_back(wb_wdata[7:0]);
      tx_pending = tx_q.size();
    end else if (wb_we) begin
      // other register writes have no effect
    end else if (wb_adr == MMIO_BASE + TXDATA_OFS) begin
      compare("wb_rdata", wb_rdata, '0);
    end else if (wb_adr == MMIO_BASE + RXDATA_OFS) begin
      compare("wb_rdata", wb_rdata, DATA_W'(rx_model));
      rx_held = 1'b0;
      compare("irq", DATA_W'(irq), DATA_W'(rx_held));
    end else begin
      compare("wb_rdata", wb_rdata, DATA_W'({rx_held, tx_pending != 0}));
      compare("irq", DATA_W'(irq), DATA_W'(rx_held));
    end
  endtask

  // serial frame sampled mid bit, after the start bit is seen
  task automatic decode_frame(input logic use_rx, output logic [7:0] b, output logic stop);
    repeat (CLKS_PER_BIT / 2) @(posedge clock);
    #5;
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(posedge clock);
      #5;
      b[i] = use_rx ? rx : tx;
    end
    repeat (CLKS_PER_BIT) @(posedge clock);
    #5;
    stop = use_rx ? rx : tx;
  endtask

  always @(posedge clock) begin
    #5;
    cycle++;
    if (test_num != cur_test) begin
      if (cur_test != 0 && test_errs == 0) begin
        $display("test %0d: passed", cur_test);
        n_pass++;
      end else if (cur_test != 0) begin
        $display("test %0d: failed with %0d errors", cur_test, test_errs);
        n_fail++;
      end
      cur_test  = test_num;
      test_errs = 0;
      if (cur_test == 1) begin
        compare("wb_ack", DATA_W'(wb_ack), '0);
        compare("wb_err", DATA_W'(wb_err), '0);
        compare("irq", DATA_W'(irq), '0);
        compare("tx", DATA_W'(tx), DATA_W'(1));
      end
    end
    // ack and err last one cycle only
    if (rst_n && !in_req && (wb_ack || wb_err)) begin
      $display("bus response with no access pending: ack %h err %h", wb_ack, wb_err);
      test_errs++;
    end
    if (rst_n && wb_cyc && wb_stb && !in_req) begin
      in_req      = 1'b1;
      start_cycle = cycle;
    end
    if (in_req && (wb_ack || wb_err)) begin
      check_response();
      in_req = 1'b0;
    end
  end

  initial begin
    logic [7:0] b;
    logic       stop;
    forever begin
      @(posedge clock);
      #5;
      if (rst_n && !tx) begin
        decode_frame(1'b0, b, stop);
        if (!stop) begin
          $display("stop bit missing on tx");
          test_errs++;
        end
        if (tx_q.size() == 0) begin
          $display("unexpected frame on tx carrying %h", b);
          test_errs++;
        end else begin
          compare("tx_byte", DATA_W'(b), DATA_W'(tx_q.pop_front()));
        end
        tx_pending = tx_q.size();
      end
    end
  end

  initial begin
    logic [7:0] b;
    logic       stop;
    forever begin
      @(posedge clock);
      #5;
      if (rst_n && !rx) begin
        decode_frame(1'b1, b, stop);
        if (stop) begin
          rx_held  = 1'b1;
          rx_model = b;
        end
      end
    end
  end

endmodule

/* sim/tb_top.sv */
`timescale 1ns/1ps

module tb_top import soc_pkg::*; ();

  logic              clock;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [DATA_W-1:0] wb_wdata;
  logic [DATA_W-1:0] wb_rdata;
  logic              wb_ack;
  logic              wb_err;
  logic              tx;
  logic              rx;
  logic              irq;
  int                test_num;
  logic              timed_out;

  logic [ADDR_W-1:0] addrs [64];

  always #20 clock = ~clock;

  soc_top dut_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .wb_err   (wb_err),
    .tx       (tx),
    .rx       (rx),
    .irq      (irq)
  );

  tb_checker chk_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .wb_err   (wb_err),
    .tx       (tx),
    .rx       (rx),
    .irq      (irq),
    .test_num (test_num)
  );

  // one wishbone classic access, held until ack or err
  task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] wdata);
    int n;
    @(negedge clock);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_wdata = wdata;
    n = 0;
    do begin
      @(negedge clock);
      n++;
    end while (!wb_ack && !wb_err && n < 400);
    if (!wb_ack && !wb_err) begin
      $display("timeout: no bus response for address %h", adr);
      timed_out = 1'b1;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic send_rx(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clock);
      rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(negedge clock);
    end
  endtask

  task automatic wait_tx_idle();
    int n;
    n = 0;
    while (chk_i.tx_pending != 0 && n < 2000) begin
      @(negedge clock);
      n++;
    end
    if (chk_i.tx_pending != 0) begin
      $display("timeout: tx frames never finished");
      timed_out = 1'b1;
    end
    // let the stop bit and busy flag run out
    repeat (2 * CLKS_PER_BIT) @(negedge clock);
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (!irq && n < 400) begin
      @(negedge clock);
      n++;
    end
    if (!irq) begin
      $display("timeout: irq never rose after a received byte");
      timed_out = 1'b1;
    end
  endtask

  initial begin
    wait (timed_out);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int               j;
    logic [ADDR_W-1:0] a;
    clock     = 1'b0;
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_wdata  = '0;
    rx        = 1'b1;
    test_num  = 0;
    timed_out = 1'b0;
    void'($urandom(27));
    repeat (8) @(negedge clock);
    rst_n = 1'b1;
    repeat (2) @(negedge clock);

    test_num = 1;
    bus_access(1'b0, MMIO_BASE + STATUS_OFS, '0);

    test_num = 2;
    for (int i = 0; i < 64; i++) begin
      addrs[i] = ADDR_W'($urandom_range(0, MEM_WORDS - 1) * 4);
      bus_access(1'b1, MEM_BASE + addrs[i], $urandom);
    end
    for (int i = 63; i > 0; i--) begin
      j = int'($urandom_range(0, i));
      a = addrs[i];
      addrs[i] = addrs[j];
      addrs[j] = a;
    end
    for (int i = 0; i < 64; i++) begin
      bus_access(1'b0, MEM_BASE + addrs[i], '0);
    end

    test_num = 3;
    for (int i = 0; i < 16; i++) begin
      do begin
        a = ADDR_W'($urandom) & 16'hFFFC;
      end while (a < ADDR_W'(MEM_WORDS * 4) || (a >= MMIO_BASE && a <= MMIO_BASE + STATUS_OFS));
      bus_access(1'($urandom_range(0, 1)), a, $urandom);
    end
    bus_access(1'b0, MMIO_BASE + 16'h000C, '0);
    for (int i = 0; i < 8; i++) begin
      bus_access(1'b0, MEM_BASE + addrs[i], '0);
    end

    test_num = 4;
    bus_access(1'b1, MMIO_BASE + TXDATA_OFS, DATA_W'($urandom_range(0, 255)));
    bus_access(1'b0, MMIO_BASE + STATUS_OFS, '0);
    wait_tx_idle();

    test_num = 5;
    bus_access(1'b1, MMIO_BASE + TXDATA_OFS, DATA_W'($urandom_range(0, 255)));
    bus_access(1'b1, MMIO_BASE + TXDATA_OFS, DATA_W'($urandom_range(0, 255)));
    wait_tx_idle();

    test_num = 6;
    send_rx(8'($urandom_range(0, 255)));
    wait_irq();
    bus_access(1'b0, MMIO_BASE + STATUS_OFS, '0);
    bus_access(1'b0, MMIO_BASE + RXDATA_OFS, '0);
    bus_access(1'b0, MMIO_BASE + STATUS_OFS, '0);

    // closes the last test in the checker
    test_num = 7;
    repeat (2) @(negedge clock);
    $display("tests passed %0d failed %0d", chk_i.n_pass, chk_i.n_fail);
    if (chk_i.n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
